//--- sim/sifhInput.txt
// input words: kind (00 sample, 01 command, ff end), tag or opcode, bin, repeat count
// expected results from @c0, one per endPixel in order: tag, bin, count
00 11 03 02
00 11 0a 03
00 11 20 01
00 11 03 01
00 11 0a 02
01 01 00 01
00 22 07 04  // back-to-back hits on one bin
00 22 08 01
00 22 07 01
00 22 08 01
00 22 07 01
01 01 00 01
00 33 09 14  // 20 hits, saturates
00 33 04 11
00 33 02 0e
01 01 00 01
00 44 09 02
00 44 02 01
01 01 00 01
01 01 00 01  // empty pixel
00 55 3f 02
01 00 00 01  // no-op
00 55 00 02
01 07 00 01  // unknown opcode, ignored
00 56 3f 01
01 01 00 01
00 66 00 03
00 66 30 03
01 01 00 01
00 77 3f 01
01 01 00 01
ff 00 00 00
@c0
11 0a 05
22 07 06
33 04 0f
44 09 02
44 00 00
56 3f 03
66 00 03
77 3f 01

//--- verilog.f
design/sifhPkg.sv
design/sampleFifo.sv
design/histRam.sv
design/histFsm.sv
design/sifhTop.sv
sim/sifh_properties.sv
sim/sifhTb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log for the fail message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module sifhTb \
    -f verilog.f -o sifhSim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sifhSim > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log

grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended without a pass"; exit 1; }
echo "simulation passed"

//--- sim/sifhTb.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTb import sifhPkg::*; ();

    localparam int          CNT_W      = 4;      // small counts so saturation is reachable
    localparam int          FIFO_DEPTH = 4;
    localparam int          MEM_SIZE   = 256;
    localparam int          RES_BASE   = 'hc0;   // expected results in the data file
    localparam int          RES_POOL   = 1;      // result slots the consumer owns
    localparam int          GRANT_BITS = 5;      // LFSR ones needed for one credit
    localparam logic [7:0]  KIND_CMD   = 8'h01;
    localparam logic [7:0]  KIND_END   = 8'hff;
    localparam logic [31:0] SEED       = 32'h410b;

    logic              clk;
    logic              res;
    logic              inValid;
    logic [WORD_W-1:0] inWord;
    logic              resCredit;
    logic              inCredit;
    logic              resValid;
    logic [TAG_W-1:0]  resTag;
    logic [BIN_W-1:0]  resBin;
    logic [CNT_W-1:0]  resCount;

    logic [7:0]        stim [MEM_SIZE];
    logic [WORD_W-1:0] wordQ [$];       // expanded input words in send order
    logic [31:0]       lfsr;
    int                nRes;
    int                resIdx;
    int                inCreds;         // credits held by the source
    int                resOwed;         // result credits granted, not yet used
    int                cycles;
    int                limit;

    sifhTop #(
        .CNT_W      (CNT_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk       (clk),
        .res       (res),
        .inValid   (inValid),
        .inWord    (inWord),
        .resCredit (resCredit),
        .inCredit  (inCredit),
        .resValid  (resValid),
        .resTag    (resTag),
        .resBin    (resBin),
        .resCount  (resCount)
    );

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
        end
        return s >> 1;
    endfunction

    function automatic logic takeBit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsrStep(lfsr);
        return b;
    endfunction

    function automatic logic [WORD_W-1:0] buildWord(input logic [7:0] kind,
                                                   input logic [7:0] field,
                                                   input logic [7:0] bin);
        sifhWord w;
        if (kind == KIND_CMD) begin
            w.cmdView.isCmd  = 1'b1;
            w.cmdView.opcode = sifhOp'(field[3:0]);
            w.cmdView.spare  = '0;
        end else begin
            w.sampleView.isCmd = 1'b0;
            w.sampleView.tag   = field;
            w.sampleView.bin   = bin[BIN_W-1:0];
        end
        return w;
    endfunction

    task automatic stopWithFail();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            stopWithFail();
        end
    endtask

    // four columns per input line, expanded by the repeat column
    task automatic loadStimulus();
        int p;
        int r;
        for (p = 0; p < MEM_SIZE; p++) begin
            stim[p] = KIND_END;
        end
        $readmemh("sim/sifhInput.txt", stim);
        nRes = 0;
        p    = 0;
        while (p < RES_BASE && stim[p] != KIND_END) begin
            for (r = 0; r < int'(stim[p+3]); r++) begin
                wordQ.push_back(buildWord(stim[p], stim[p+1], stim[p+2]));
            end
            if (stim[p] == KIND_CMD && stim[p+1][3:0] == 4'(opEndPixel)) begin
                nRes++;                          // one result per endPixel
            end
            p += 4;
        end
        if (nRes == 0) begin
            $display("stimulus file holds no endPixel command, nothing to check");
            stopWithFail();
        end
    endtask

    task automatic checkResult();
        int b;
        b = RES_BASE + 3 * resIdx;
        checkEq(32'(resTag), 32'(stim[b]), $sformatf("result %0d tag", resIdx));
        checkEq(32'(resBin), 32'(stim[b+1]), $sformatf("result %0d bin", resIdx));
        checkEq(32'(resCount), 32'(stim[b+2]), $sformatf("result %0d count", resIdx));
        resIdx++;
    endtask

    // consumer grants a slot only after a run of LFSR ones
    task automatic driveConsumer();
        logic grant;
        int   k;
        resCredit = 1'b0;
        if (resOwed < RES_POOL) begin
            grant = 1'b1;
            for (k = 0; k < GRANT_BITS; k++) begin
                grant = grant & takeBit();
            end
            if (grant) begin
                resCredit = 1'b1;
                resOwed++;
            end
        end
    endtask

    task automatic driveSource();
        if (wordQ.size() != 0 && inCreds > 0) begin
            inValid = 1'b1;
            inWord  = wordQ.pop_front();
            inCreds--;
        end else begin
            inValid = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        res       = 1'b0;
        inValid   = 1'b0;
        inWord    = '0;
        resCredit = 1'b0;
        lfsr      = SEED;
        resIdx    = 0;
        inCreds   = 0;
        resOwed   = 0;
        cycles    = 0;
        loadStimulus();
        limit = (wordQ.size() + 80 * nRes) * 4;
        repeat (8) @(posedge clk);
        #2;
        res = 1'b1;
        while (resIdx < nRes && cycles < limit) begin
            @(posedge clk);
            #2;                                  // outputs settled, inputs change here
            cycles++;
            if (inCredit) begin
                inCreds++;
            end
            checkEq(32'(inCreds >= 0 && inCreds <= FIFO_DEPTH), 32'd1,
                    "source input credit count out of range");
            if (resValid) begin
                checkEq(32'(resOwed > 0), 32'd1, "result sent without a result credit");
                checkResult();
                resOwed--;
            end
            driveConsumer();
            driveSource();
        end
        if (resIdx == nRes) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("timeout: results stopped arriving, %0d of %0d seen after %0d cycles",
                     resIdx, nRes, cycles);
            stopWithFail();
        end
    end

endmodule

`default_nettype wire

//--- sim/sifh_properties.sv
`timescale 1ns/1ps
`default_nettype none

module sifhProperties import sifhPkg::*; #(
    parameter int CNT_W = 16
) (
    input wire             clk,
    input wire             res,
    input wire             fifoValid,
    input wire             fifoPop,
    input wire             resCredit,
    input wire             resValid,
    input wire             rdEn,
    input wire [BIN_W-1:0] rdAddr,
    input wire             wrEn,
    input wire [BIN_W-1:0] wrAddr,
    input wire [CNT_W-1:0] wrData
);

    logic [15:0] granted;   // credits seen minus results sent

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            granted <= '0;
        end else begin
            granted <= granted + 16'(resCredit) - 16'(resValid);
        end
    end

    popOnlyWhenValid: assert property (
        @(posedge clk) disable iff (!res) fifoPop |-> fifoValid)
        else $error("word popped from an empty FIFO");

    resultNeedsCredit: assert property (
        @(posedge clk) disable iff (!res) resValid |-> granted != '0)
        else $error("result sent without a result credit");

    // same bin read and written together, next write must build on the count just written
    noLostUpdate: assert property (
        @(posedge clk) disable iff (!res)
        (rdEn && wrEn && rdAddr == wrAddr)
        |=> wrEn && wrAddr == $past(wrAddr)
            && wrData == (($past(wrData) == '1) ? $past(wrData) : $past(wrData) + 1'b1))
        else $error("same-bin read and write lost an update");

endmodule

bind histFsm sifhProperties #(
    .CNT_W (CNT_W)
) uProps (
    .clk       (clk),
    .res       (res),
    .fifoValid (fifoValid),
    .fifoPop   (fifoPop),
    .resCredit (resCredit),
    .resValid  (resValid),
    .rdEn      (rdEn),
    .rdAddr    (rdAddr),
    .wrEn      (wrEn),
    .wrAddr    (wrAddr),
    .wrData    (wrData)
);

`default_nettype wire

//--- design/sifhTop.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTop import sifhPkg::*; #(
    parameter int CNT_W      = 16,
    parameter int FIFO_DEPTH = 4
) (
    input  wire               clk,
    input  wire               res,
    input  wire               inValid,
    input  wire  [WORD_W-1:0] inWord,
    input  wire               resCredit,
    output logic              inCredit,
    output logic              resValid,
    output logic [TAG_W-1:0]  resTag,
    output logic [BIN_W-1:0]  resBin,
    output logic [CNT_W-1:0]  resCount
);

    logic              fifoValid;
    logic [WORD_W-1:0] fifoWord;
    logic              fifoPop;

    logic              rdEn;
    logic [BIN_W-1:0]  rdAddr;
    logic [CNT_W-1:0]  rdData;
    logic              wrEn;
    logic [BIN_W-1:0]  wrAddr;
    logic [CNT_W-1:0]  wrData;

    sampleFifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uFifo (
        .clk       (clk),
        .res       (res),
        .inValid   (inValid),
        .inWord    (inWord),
        .fifoPop   (fifoPop),
        .inCredit  (inCredit),
        .fifoValid (fifoValid),
        .fifoWord  (fifoWord)
    );

    histFsm #(
        .CNT_W (CNT_W)
    ) uFsm (
        .clk       (clk),
        .res       (res),
        .fifoValid (fifoValid),
        .fifoWord  (fifoWord),
        .resCredit (resCredit),
        .rdData    (rdData),
        .fifoPop   (fifoPop),
        .rdEn      (rdEn),
        .rdAddr    (rdAddr),
        .wrEn      (wrEn),
        .wrAddr    (wrAddr),
        .wrData    (wrData),
        .resValid  (resValid),
        .resTag    (resTag),
        .resBin    (resBin),
        .resCount  (resCount)
    );

    histRam #(
        .CNT_W (CNT_W)
    ) uRam (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

endmodule

`default_nettype wire

//--- design/histFsm.sv
`timescale 1ns/1ps
`default_nettype none

module histFsm import sifhPkg::*; #(
    parameter int CNT_W = 16
) (
    input  wire               clk,
    input  wire               res,
    input  wire               fifoValid,
    input  wire  [WORD_W-1:0] fifoWord,
    input  wire               resCredit,
    input  wire  [CNT_W-1:0]  rdData,
    output logic              fifoPop,
    output logic              rdEn,
    output logic [BIN_W-1:0]  rdAddr,
    output logic              wrEn,
    output logic [BIN_W-1:0]  wrAddr,
    output logic [CNT_W-1:0]  wrData,
    output logic              resValid,
    output logic [TAG_W-1:0]  resTag,
    output logic [BIN_W-1:0]  resBin,
    output logic [CNT_W-1:0]  resCount
);

    localparam int SWEEP_W = BIN_W + 1;   // counts 0..NUM_BINS
    localparam int CRED_W  = 8;

    typedef enum logic [2:0] {
        initClear,
        idle,
        accumulate,
        drain,
        sweep,
        resultWait
    } stateT;

    stateT              state;
    logic [SWEEP_W-1:0] sweepCnt;
    logic               clearOnly;    // reset sweep, no result
    logic [CRED_W-1:0]  resCredits;   // result slots granted by consumer

    sifhWord            word;
    logic               isSample;
    logic               isEnd;
    logic               popSample;

    // stage 2 of the read-modify-write
    logic               s2Valid;
    logic [BIN_W-1:0]   s2Bin;
    logic               fwdHit;       // previous write went to this bin
    logic [CNT_W-1:0]   lastWr;
    logic [CNT_W-1:0]   base;
    logic [CNT_W-1:0]   incr;
    logic [TAG_W-1:0]   lastTag;

    logic               sweepRd;
    logic               sweepWr;
    logic [BIN_W-1:0]   sweepBin;     // bin whose count arrives this cycle

    assign word      = fifoWord;
    assign isSample  = !word.sampleView.isCmd;
    assign isEnd     = word.cmdView.isCmd && (word.cmdView.opcode == opEndPixel);
    assign fifoPop   = fifoValid && (state == idle || state == accumulate);
    assign popSample = fifoPop && isSample;

    // saturating increment, forwarded when the RAM copy is one write behind
    assign base = fwdHit ? lastWr : rdData;
    assign incr = (&base) ? base : base + 1'b1;

    assign sweepRd  = (state == sweep) && (sweepCnt < SWEEP_W'(NUM_BINS));
    assign sweepWr  = (state == sweep) && (sweepCnt != '0);
    assign sweepBin = BIN_W'(sweepCnt - 1'b1);

    // RAM ports, accumulation and sweep never overlap
    assign rdEn   = popSample || sweepRd;
    assign rdAddr = popSample ? word.sampleView.bin : sweepCnt[BIN_W-1:0];
    assign wrEn   = s2Valid || sweepWr;
    assign wrAddr = s2Valid ? s2Bin : sweepBin;
    assign wrData = s2Valid ? incr : '0;          // zero behind the sweep

    assign resValid = (state == resultWait) && (resCredits != '0);
    assign resTag   = lastTag;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s2Valid <= 1'b0;
            fwdHit  <= 1'b0;
            lastTag <= '0;
        end else begin
            s2Valid <= popSample;
            fwdHit  <= popSample && s2Valid && (word.sampleView.bin == s2Bin);
            if (popSample) begin
                lastTag <= word.sampleView.tag;   // last tag before endPixel wins
            end
        end
    end

    always_ff @(posedge clk) begin
        if (popSample) begin
            s2Bin <= word.sampleView.bin;
        end
        if (s2Valid) begin
            lastWr <= incr;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= initClear;
            sweepCnt  <= '0;
            clearOnly <= 1'b1;
            resBin    <= '0;
            resCount  <= '0;
        end else begin
            case (state)
                initClear: begin
                    clearOnly <= 1'b1;
                    sweepCnt  <= '0;
                    state     <= sweep;
                end
                idle, accumulate: begin
                    if (!fifoPop) begin
                        state <= idle;
                    end else if (isSample) begin
                        state <= accumulate;
                    end else if (isEnd) begin
                        state <= drain;
                    end
                end
                drain: begin                         // last write lands here
                    clearOnly <= 1'b0;
                    sweepCnt  <= '0;
                    resBin    <= '0;                 // empty pixel gives bin 0, count 0
                    resCount  <= '0;
                    state     <= sweep;
                end
                sweep: begin
                    sweepCnt <= sweepCnt + 1'b1;
                    // strict compare keeps the lowest bin on a tie
                    if (sweepWr && rdData > resCount) begin
                        resBin   <= sweepBin;
                        resCount <= rdData;
                    end
                    if (sweepCnt == SWEEP_W'(NUM_BINS)) begin
                        state <= clearOnly ? idle : resultWait;
                    end
                end
                resultWait: begin
                    if (resValid) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // result credit pool
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            resCredits <= '0;
        end else begin
            resCredits <= resCredits + CRED_W'(resCredit) - CRED_W'(resValid);
        end
    end

endmodule

`default_nettype wire

//--- design/histRam.sv
`timescale 1ns/1ps
`default_nettype none

module histRam import sifhPkg::*; #(
    parameter int CNT_W = 16
) (
    input  wire              clk,
    input  wire              wrEn,
    input  wire  [BIN_W-1:0] wrAddr,
    input  wire  [CNT_W-1:0] wrData,
    input  wire              rdEn,
    input  wire  [BIN_W-1:0] rdAddr,
    output logic [CNT_W-1:0] rdData
);

    logic [CNT_W-1:0] mem [NUM_BINS];   // one count per bin

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- design/sampleFifo.sv
`timescale 1ns/1ps
`default_nettype none

module sampleFifo import sifhPkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire               clk,
    input  wire               res,
    input  wire               inValid,
    input  wire  [WORD_W-1:0] inWord,
    input  wire               fifoPop,
    output logic              inCredit,
    output logic              fifoValid,
    output logic [WORD_W-1:0] fifoWord
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

    logic [WORD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wrPtr;
    logic [PTR_W-1:0]  rdPtr;
    logic [LVL_W-1:0]  level;        // words held
    logic [LVL_W-1:0]  initLeft;     // initial credits not yet issued

    // pointer wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (inValid) begin
            mem[wrPtr] <= inWord;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            level    <= '0;
            initLeft <= LVL_W'(FIFO_DEPTH);
            inCredit <= 1'b0;
        end else begin
            if (inValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (fifoPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({inValid, fifoPop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase

            // a pop returns its slot at once, the initial pool waits behind it
            inCredit <= fifoPop || (initLeft != '0);
            if (!fifoPop && initLeft != '0) begin
                initLeft <= initLeft - 1'b1;
            end
        end
    end

    assign fifoValid = (level != '0);
    assign fifoWord  = mem[rdPtr];   // head word, valid with fifoValid

endmodule

`default_nettype wire

//--- design/sifhPkg.sv
`default_nettype none

package sifhPkg;

    localparam int BIN_W    = 6;                    // 64 arrival-time bins
    localparam int TAG_W    = 8;                    // pixel tag
    localparam int WORD_W   = 1 + TAG_W + BIN_W;    // isCmd + tag + bin
    localparam int NUM_BINS = 1 << BIN_W;

    // command opcodes, any value other than endPixel is consumed as a no-op
    typedef enum logic [3:0] {
        opNop      = 4'h0,
        opEndPixel = 4'h1                           // close pixel, start peak search
    } sifhOp;

    // bin sample, isCmd low
    typedef struct packed {
        logic             isCmd;
        logic [TAG_W-1:0] tag;
        logic [BIN_W-1:0] bin;
    } sifhSample;

    // command word, isCmd high
    typedef struct packed {
        logic              isCmd;
        sifhOp             opcode;
        logic [WORD_W-6:0] spare;                   // unused, send as zero
    } sifhCmd;

    // one input word, seen as sample or as command
    typedef union packed {
        sifhSample sampleView;
        sifhCmd    cmdView;
    } sifhWord;

endpackage

`default_nettype wire
